//--- tb.f
+incdir+bench
src/hssl_pkg.sv
src/pkt_fifo.sv
src/link_timer.sv
src/link_fsm.sv
src/tx_control.sv
src/rx_control.sv
src/hssl_interface.sv
bench/hssl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module hssl_tb -o hssl_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/hssl_sim > sim.log 2>&1
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- bench/hssl_tb_tasks.svh
`ifndef HSSL_TB_TASKS_SVH
`define HSSL_TB_TASKS_SVH

// ----------------------------------------------------------------------
// checking and model
// ----------------------------------------------------------------------
task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
  n_checks++;
  if (got !== exp) begin
    err_count++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

// oldest outstanding packet must match
task automatic receive_packet();
  pkt_t exp;
  n_recv++;
  if (model_q.size() == 0) begin
    err_count++;
    $display("error at %0t: packet %h arrived with none outstanding", $time, rx_data);
  end else begin
    exp = model_q.pop_front();
    check("rx_data", 64'(rx_data), 64'(exp));
  end
endtask

// xor of the eight bytes, folded in halves
function automatic logic [7:0] fold_xor(input pkt_t pkt);
  logic [31:0] w;
  logic [15:0] h;
  w = pkt[63:32] ^ pkt[31:0];
  h = w[31:16] ^ w[15:0];
  return h[15:8] ^ h[7:0];
endfunction

task automatic end_test(input string name, input int errs_before);
  n_tests++;
  if (err_count == errs_before) begin
    $display("test %0d %s: pass", n_tests, name);
  end else begin
    $display("test %0d %s: fail, %0d errors", n_tests, name, err_count - errs_before);
  end
endtask

// ----------------------------------------------------------------------
// stimulus
// ----------------------------------------------------------------------
task automatic next_drive();
  @(posedge clk);
  #1;
endtask

task automatic apply_reset();
  arst_n = 1'b0;
  repeat (10) @(posedge clk);
  #1 arst_n = 1'b1;
endtask

// called just after an edge, returns just after one
task automatic send_packets(input int n, input bit throttle);
  int sent;
  sent = 0;
  while (sent < n) begin
    if (!throttle || (($random(seed) & 1) != 0)) begin
      tx_data = {$random(seed), $random(seed)};
      tx_vld  = 1'b1;
      // held until the DUT takes it
      @(negedge clk);
      while (!tx_rdy) begin
        @(negedge clk);
      end
      sent++;
    end else begin
      tx_vld = 1'b0;
    end
    next_drive();
  end
  tx_vld = 1'b0;
endtask

task automatic drain(input int limit);
  int n;
  n = 0;
  while (model_q.size() != 0 && n < limit) begin
    next_drive();
    n++;
  end
  if (model_q.size() != 0) begin
    err_count++;
    $display("error at %0t: %0d packets not delivered within %0d cycles", $time,
             model_q.size(), limit);
  end
endtask

// 0 handshake_complete, 1 frame_err, else version_mismatch
function automatic logic flag_value(input int which);
  case (which)
    0:       return handshake_complete;
    1:       return frame_err;
    default: return version_mismatch;
  endcase
endfunction

task automatic wait_flag(input int which, input string name, input int limit);
  int n;
  bit seen;
  n    = 0;
  seen = 1'b0;
  while (!seen && n < limit) begin
    @(negedge clk);
    seen = flag_value(which);
    n++;
  end
  if (!seen) begin
    err_count++;
    $display("error at %0t: %s did not rise within %0d cycles", $time, name, limit);
  end
endtask

`endif

//--- bench/hssl_tb.sv
`timescale 1ns/1ps
module hssl_tb
  import hssl_pkg::*;
();

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic [15:0]          link_id;
  pkt_t                 tx_data;
  logic                 tx_vld;
  logic                 tx_rdy;
  pkt_t                 rx_data;
  logic                 rx_vld;
  logic                 rx_rdy = 1'b0;
  logic [WORD_BITS-1:0] userdata_tx;
  logic [WORD_BITS-1:0] userdata_rx;
  logic [K_BITS-1:0]    txcharisk;
  logic [K_BITS-1:0]    rxcharisk;
  logic                 handshake_complete;
  logic                 version_mismatch;
  logic                 frame_err;
  logic [15:0]          reg_idsi;

  // fault injection on the loopback
  logic                 flip_version = 1'b0;
  logic                 flip_data = 1'b0;
  logic [WORD_BITS-1:0] fault_mask;
  // rx readiness: 0 always, 1 held off, 2 random 75%
  int                   rdy_mode = 0;
  logic                 rdy_next;

  integer               seed;
  pkt_t                 model_q[$];
  int                   err_count = 0;
  int                   n_checks = 0;
  int                   n_tests = 0;
  int                   n_recv = 0;
  int                   n_frame_err = 0;
  int                   cycles = 0;

  `include "hssl_tb_tasks.svh"

  always #50 clk = ~clk;

  hssl_interface dut0 (
      .hsslif_clk         (clk)
    , .arst_n             (arst_n)
    , .link_id            (link_id)
    , .tx_data            (tx_data)
    , .tx_vld             (tx_vld)
    , .tx_rdy             (tx_rdy)
    , .rx_data            (rx_data)
    , .rx_vld             (rx_vld)
    , .rx_rdy             (rx_rdy)
    , .userdata_tx        (userdata_tx)
    , .txcharisk          (txcharisk)
    , .userdata_rx        (userdata_rx)
    , .rxcharisk          (rxcharisk)
    , .handshake_complete (handshake_complete)
    , .version_mismatch   (version_mismatch)
    , .frame_err          (frame_err)
    , .reg_idsi           (reg_idsi)
  );

  // ----------------------------------------------------------------------
  // loopback channel
  // ----------------------------------------------------------------------
  always_comb begin
    fault_mask = '0;
    // wrong version byte in every handshake
    if (flip_version && txcharisk == KMSK_CTRL && userdata_tx[7:0] == K_HSHK) begin
      fault_mask[15:8] = 8'hFF;
    end
    // one payload bit of a data word
    if (flip_data && txcharisk == KMSK_DATA) begin
      fault_mask[5] = 1'b1;
    end
  end

  assign userdata_rx = userdata_tx ^ fault_mask;
  assign rxcharisk   = txcharisk;

  // rx_rdy decided at the edge, driven just after it
  always @(posedge clk) begin
    case (rdy_mode)
      0:       rdy_next = 1'b1;
      1:       rdy_next = 1'b0;
      default: rdy_next = (($random(seed) & 3) != 0);
    endcase
    #1 rx_rdy = rdy_next;
  end

  // transfers sampled mid-cycle, where both sides are stable
  always @(negedge clk) begin
    if (arst_n) begin
      if (tx_vld && tx_rdy) begin
        model_q.push_back(tx_data);
      end
      if (rx_vld && rx_rdy) begin
        receive_packet();
      end
      if (frame_err) begin
        n_frame_err++;
      end
    end
  end

  // about 1100 cycles of tests, limit well above
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int   errs;
    int   base_recv;
    int   base_ferr;
    int   n;
    pkt_t dropped;
    seed    = 9;
    arst_n  = 1'b0;
    link_id = 16'hA5C3;
    tx_data = '0;
    tx_vld  = 1'b0;
    apply_reset();

    // bring-up
    errs = err_count;
    @(negedge clk);
    check("tx_rdy", 64'(tx_rdy), 64'd0);
    check("rx_vld", 64'(rx_vld), 64'd0);
    check("handshake_complete", 64'(handshake_complete), 64'd0);
    check("frame_err", 64'(frame_err), 64'd0);
    wait_flag(0, "handshake_complete", 50);
    check("version_mismatch", 64'(version_mismatch), 64'd0);
    check("reg_idsi", 64'(reg_idsi), 64'(link_id));
    // idle filler on the tx port, field by field
    check("txcharisk", 64'(txcharisk), 64'(4'b0001));
    check("userdata_tx byte0", 64'(userdata_tx[7:0]), 64'(K_HSHK));
    check("userdata_tx version", 64'(userdata_tx[15:8]), 64'(HSSL_VERSION));
    check("userdata_tx link_id", 64'(userdata_tx[31:16]), 64'(link_id));
    end_test("bring-up", errs);
    next_drive();

    // random traffic, tx_vld half the time
    errs      = err_count;
    base_recv = n_recv;
    base_ferr = n_frame_err;
    send_packets(200, 1'b1);
    drain(200);
    check("packets received", 64'(n_recv - base_recv), 64'd200);
    check("frame_err pulses", 64'(n_frame_err - base_ferr), 64'd0);
    end_test("data transfer", errs);

    // rx held off, 12 packets fit in the rx FIFO
    errs      = err_count;
    base_recv = n_recv;
    base_ferr = n_frame_err;
    rdy_mode  = 1;
    next_drive();
    next_drive();
    send_packets(12, 1'b0);
    repeat (60) next_drive();
    // oldest packet waits at the rx head
    check("rx_data", 64'(rx_data), 64'(model_q[0]));
    check("rx_vld", 64'(rx_vld), 64'd1);
    rdy_mode = 2;
    drain(200);
    rdy_mode = 0;
    check("packets received", 64'(n_recv - base_recv), 64'd12);
    check("frame_err pulses", 64'(n_frame_err - base_ferr), 64'd0);
    end_test("back-pressure", errs);

    // one frame hit in its low data word
    errs      = err_count;
    base_recv = n_recv;
    base_ferr = n_frame_err;
    flip_data = 1'b1;
    send_packets(1, 1'b0);
    // lost in the channel, so out of the model
    dropped = model_q.pop_front();
    n = 0;
    @(negedge clk);
    while (!(txcharisk == KMSK_CTRL && userdata_tx[7:0] == K_SOF) && n < 20) begin
      @(negedge clk);
      n++;
    end
    // start word, then the low half that the channel corrupts
    check("userdata_tx byte0", 64'(userdata_tx[7:0]), 64'(K_SOF));
    check("frame checksum", 64'(userdata_tx[15:8]), 64'(fold_xor(dropped)));
    check("userdata_tx bytes 2-3", 64'(userdata_tx[31:16]), 64'd0);
    @(negedge clk);
    check("txcharisk", 64'(txcharisk), 64'd0);
    check("userdata_tx", 64'(userdata_tx), 64'(dropped[31:0]));
    next_drive();
    flip_data = 1'b0;
    wait_flag(1, "frame_err", 20);
    next_drive();
    send_packets(20, 1'b1);
    drain(200);
    check("packets received", 64'(n_recv - base_recv), 64'd20);
    check("frame_err pulses", 64'(n_frame_err - base_ferr), 64'd1);
    end_test("corrupted frame", errs);

    // partner with the wrong version, fresh reset
    errs         = err_count;
    flip_version = 1'b1;
    apply_reset();
    wait_flag(2, "version_mismatch", 20);
    next_drive();
    tx_data = {$random(seed), $random(seed)};
    tx_vld  = 1'b1;
    n = 0;
    while (n < 100 && err_count == errs) begin
      @(negedge clk);
      check("version_mismatch", 64'(version_mismatch), 64'd1);
      check("handshake_complete", 64'(handshake_complete), 64'd0);
      check("tx_rdy", 64'(tx_rdy), 64'd0);
      n++;
    end
    next_drive();
    tx_vld = 1'b0;
    end_test("version mismatch", errs);

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src/hssl_interface.sv
`timescale 1ns/1ps
module hssl_interface
  import hssl_pkg::*;
(
  input  logic                 hsslif_clk,
  input  logic                 arst_n,

  input  logic [15:0]          link_id,

  // packet in
  input  pkt_t                 tx_data,
  input  logic                 tx_vld,
  output logic                 tx_rdy,

  // packet out
  output pkt_t                 rx_data,
  output logic                 rx_vld,
  input  logic                 rx_rdy,

  // transceiver user ports
  output logic [WORD_BITS-1:0] userdata_tx,
  output logic [K_BITS-1:0]    txcharisk,
  input  logic [WORD_BITS-1:0] userdata_rx,
  input  logic [K_BITS-1:0]    rxcharisk,

  // status
  output logic                 handshake_complete,
  output logic                 version_mismatch,
  output logic                 frame_err,
  output logic [15:0]          reg_idsi
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  link_state_t link_state;
  pkt_t        tx_head;
  pkt_t        rx_push_data;
  logic        tx_full;
  logic        tx_empty;
  logic        tx_pop;
  logic        rx_push;
  logic        rx_full;
  logic        rx_empty;
  logic        hs_good;
  logic        hs_bad;
  logic        hs_done;
  logic        timer_clear;

  // packets accepted only on a live link
  assign tx_rdy = (link_state == LINK_UP) && !tx_full;
  assign rx_vld = !rx_empty;

  wire tx_push = tx_vld && tx_rdy;
  wire rx_pop  = rx_vld && rx_rdy;

  // ----------------------------------------------------------------------
  // packet buffers
  // ----------------------------------------------------------------------
  pkt_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
      .clk       (hsslif_clk)
    , .arst_n    (arst_n)
    , .push      (tx_push)
    , .push_data (tx_data)
    , .pop       (tx_pop)
    , .pop_data  (tx_head)
    , .empty     (tx_empty)
    , .full      (tx_full)
  );

  pkt_fifo #(.DEPTH(RX_DEPTH)) rx_fifo (
      .clk       (hsslif_clk)
    , .arst_n    (arst_n)
    , .push      (rx_push)
    , .push_data (rx_push_data)
    , .pop       (rx_pop)
    , .pop_data  (rx_data)
    , .empty     (rx_empty)
    , .full      (rx_full)
  );

  // ----------------------------------------------------------------------
  // link bring-up
  // ----------------------------------------------------------------------
  link_timer link_timer_i (
      .clk     (hsslif_clk)
    , .arst_n  (arst_n)
    , .hs_good (hs_good)
    , .hs_bad  (hs_bad)
    , .clear   (timer_clear)
    , .hs_done (hs_done)
  );

  link_fsm link_fsm_i (
      .clk                (hsslif_clk)
    , .arst_n             (arst_n)
    , .hs_done            (hs_done)
    , .hs_bad             (hs_bad)
    , .link_state         (link_state)
    , .timer_clear        (timer_clear)
    , .handshake_complete (handshake_complete)
    , .version_mismatch   (version_mismatch)
  );

  // ----------------------------------------------------------------------
  // transceiver tx and rx words
  // ----------------------------------------------------------------------
  tx_control tx_control_i (
      .clk        (hsslif_clk)
    , .arst_n     (arst_n)
    , .link_state (link_state)
    , .link_id    (link_id)
    , .fifo_data  (tx_head)
    , .fifo_empty (tx_empty)
    , .fifo_pop   (tx_pop)
    , .txdata     (userdata_tx)
    , .txcharisk  (txcharisk)
  );

  rx_control rx_control_i (
      .clk        (hsslif_clk)
    , .arst_n     (arst_n)
    , .link_state (link_state)
    , .rxdata     (userdata_rx)
    , .rxcharisk  (rxcharisk)
    , .fifo_full  (rx_full)
    , .reg_idsi   (reg_idsi)
    , .hs_good    (hs_good)
    , .hs_bad     (hs_bad)
    , .push       (rx_push)
    , .push_data  (rx_push_data)
    , .frame_err  (frame_err)
  );

endmodule

//--- src/rx_control.sv
`timescale 1ns/1ps
module rx_control
  import hssl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  link_state_t          link_state,
  input  logic [WORD_BITS-1:0] rxdata,
  input  logic [K_BITS-1:0]    rxcharisk,
  input  logic                 fifo_full,
  output logic [15:0]          reg_idsi,
  output logic                 hs_good,
  output logic                 hs_bad,
  output logic                 push,
  output pkt_t                 push_data,
  output logic                 frame_err
);

  // next word expected
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DLO,
    RX_DHI
  } rx_phase_t;

  rx_phase_t            phase;
  logic [7:0]           csum_q;
  logic [WORD_BITS-1:0] lo_q;
  logic                 link_up;
  logic                 is_ctrl;
  logic                 is_hshk;
  logic                 is_sof;
  logic                 is_data;
  logic                 csum_ok;
  logic                 frame_done;

  // ----------------------------------------------------------------------
  // word classification
  // ----------------------------------------------------------------------
  assign link_up = (link_state == LINK_UP);
  assign is_ctrl = (rxcharisk == KMSK_CTRL);
  assign is_hshk = is_ctrl && (rxdata[7:0] == K_HSHK);
  assign is_sof  = is_ctrl && (rxdata[7:0] == K_SOF);
  assign is_data = (rxcharisk == KMSK_DATA);

  // version check on every handshake, idle fillers included
  assign hs_good = is_hshk && (rxdata[15:8] == HSSL_VERSION);
  assign hs_bad  = is_hshk && (rxdata[15:8] != HSSL_VERSION);

  // ----------------------------------------------------------------------
  // frame assembly
  // ----------------------------------------------------------------------
  // high half arrives last
  assign push_data  = {rxdata, lo_q};
  assign csum_ok    = (pkt_csum(push_data) == csum_q);
  assign frame_done = link_up && (phase == RX_DHI) && is_data;
  // pushed as the last word arrives, so rx_vld rises one cycle later
  assign push       = frame_done && csum_ok && !fifo_full;

  always_ff @(posedge clk) begin
    if (link_up && phase == RX_IDLE && is_sof) begin
      csum_q <= rxdata[15:8];
    end
    if (link_up && phase == RX_DLO && is_data) begin
      lo_q <= rxdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= RX_IDLE;
      frame_err <= 1'b0;
      reg_idsi  <= '0;
    end else begin
      frame_err <= 1'b0;
      // partner id
      if (hs_good) begin
        reg_idsi <= rxdata[31:16];
      end
      if (!link_up) begin
        // frames ignored until linked
        phase <= RX_IDLE;
      end else begin
        case (phase)
          RX_IDLE: begin
            if (is_sof) begin
              phase <= RX_DLO;
            end
          end
          RX_DLO: begin
            if (is_data) begin
              phase <= RX_DHI;
            end else begin
              // k-char inside a frame
              phase     <= RX_IDLE;
              frame_err <= 1'b1;
            end
          end
          RX_DHI: begin
            // k-char, bad checksum or no room
            phase     <= RX_IDLE;
            frame_err <= !push;
          end
          default: phase <= RX_IDLE;
        endcase
      end
    end
  end

endmodule

//--- src/tx_control.sv
`timescale 1ns/1ps
module tx_control
  import hssl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  link_state_t          link_state,
  input  logic [15:0]          link_id,
  input  pkt_t                 fifo_data,
  input  logic                 fifo_empty,
  output logic                 fifo_pop,
  output logic [WORD_BITS-1:0] txdata,
  output logic [K_BITS-1:0]    txcharisk
);

  // word on the tx port this cycle
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SOF,
    PH_DLO,
    PH_DHI
  } tx_phase_t;

  tx_phase_t            phase;
  pkt_t                 pkt_q;
  logic [WORD_BITS-1:0] hshk_word;
  logic                 frame_slot;

  // ----------------------------------------------------------------------
  // word selection
  // ----------------------------------------------------------------------
  // handshake: id in bytes 2-3, version in byte1
  assign hshk_word = {link_id, HSSL_VERSION, K_HSHK};

  // next frame may start once the last data word is out
  assign frame_slot = (phase == PH_IDLE) || (phase == PH_DHI);
  assign fifo_pop   = (link_state == LINK_UP) && frame_slot && !fifo_empty;

  // packet held for the two data words
  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      pkt_q <= fifo_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= PH_IDLE;
      txdata    <= '0;
      txcharisk <= KMSK_DATA;
    end else if (link_state != LINK_UP) begin
      // handshake every cycle until linked
      phase     <= PH_IDLE;
      txdata    <= hshk_word;
      txcharisk <= KMSK_CTRL;
    end else begin
      case (phase)
        PH_SOF: begin
          // low half first
          phase     <= PH_DLO;
          txdata    <= pkt_q[WORD_BITS-1:0];
          txcharisk <= KMSK_DATA;
        end
        PH_DLO: begin
          phase     <= PH_DHI;
          txdata    <= pkt_q[PKT_BITS-1:WORD_BITS];
          txcharisk <= KMSK_DATA;
        end
        default: begin
          if (fifo_pop) begin
            // start word carries the checksum in byte1
            phase     <= PH_SOF;
            txdata    <= {16'h0000, pkt_csum(fifo_data), K_SOF};
            txcharisk <= KMSK_CTRL;
          end else begin
            // idle filler, lets a slower partner finish
            phase     <= PH_IDLE;
            txdata    <= hshk_word;
            txcharisk <= KMSK_CTRL;
          end
        end
      endcase
    end
  end

  // tx fifo only fills once the link is up, so no pop on the first up cycle
  assert property (@(posedge clk) disable iff (!arst_n)
    fifo_pop |-> $past(link_state) == LINK_UP)
    else $error("tx_control: fifo popped outside LINK_UP");

endmodule

//--- src/link_fsm.sv
`timescale 1ns/1ps
module link_fsm
  import hssl_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        hs_done,
  input  logic        hs_bad,
  output link_state_t link_state,
  output logic        timer_clear,
  output logic        handshake_complete,
  output logic        version_mismatch
);

  link_state_t state_nxt;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = link_state;
    case (link_state)
      LINK_RESET: state_nxt = LINK_HSHK;
      LINK_HSHK: begin
        // a mismatch in the same cycle also blocks
        if (hs_done && !hs_bad && !version_mismatch) begin
          state_nxt = LINK_UP;
        end
      end
      // held until reset
      LINK_UP:    state_nxt = LINK_UP;
      default:    state_nxt = LINK_RESET;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link_state <= LINK_RESET;
    end else begin
      link_state <= state_nxt;
    end
  end

  // sticky mismatch flag, only watched during handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      version_mismatch <= 1'b0;
    end else if (link_state == LINK_HSHK && hs_bad) begin
      version_mismatch <= 1'b1;
    end
  end

  // timer runs only while handshaking with a matching partner
  assign timer_clear        = (link_state != LINK_HSHK) || version_mismatch;
  assign handshake_complete = (link_state == LINK_UP);

  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(handshake_complete) |-> !version_mismatch && !$past(version_mismatch))
    else $error("link_fsm: link up despite version mismatch");

endmodule

//--- src/link_timer.sv
`timescale 1ns/1ps
module link_timer
  import hssl_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic hs_good,
  input  logic hs_bad,
  input  logic clear,
  output logic hs_done
);

  // ----------------------------------------------------------------------
  // consecutive good handshake counter
  // ----------------------------------------------------------------------
  logic [HS_CNT_BITS-1:0] count;

  // saturates at the limit
  assign hs_done = (count == HS_CNT_BITS'(HS_COUNT));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (clear || hs_bad) begin
      // any bad word breaks the run
      count <= '0;
    end else if (hs_good && !hs_done) begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- src/pkt_fifo.sv
`timescale 1ns/1ps
module pkt_fifo
  import hssl_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n,
  input  logic push,
  input  pkt_t push_data,
  input  logic pop,
  output pkt_t pop_data,
  output logic empty,
  output logic full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  pkt_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // effective transfers
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  // head item always visible
  assign pop_data = mem[rd_ptr];

  // packet storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, not at a power of two
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // callers must honour the flags
  assert property (@(posedge clk) disable iff (!arst_n) full |-> !push)
    else $error("pkt_fifo: push while full");
  assert property (@(posedge clk) disable iff (!arst_n) empty |-> !pop)
    else $error("pkt_fifo: pop while empty");

endmodule

//--- src/hssl_pkg.sv
package hssl_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int PKT_BITS  = 64;
  localparam int WORD_BITS = 32;
  localparam int K_BITS    = 4;

  // 8b10b control bytes, always in byte0
  localparam logic [7:0] K_HSHK = 8'h3C;  // K28.1
  localparam logic [7:0] K_SOF  = 8'hFB;  // K27.7

  // char-is-k patterns
  localparam logic [K_BITS-1:0] KMSK_CTRL = 4'b0001;
  localparam logic [K_BITS-1:0] KMSK_DATA = 4'b0000;

  // protocol version sent in byte1 of every handshake word
  localparam logic [7:0] HSSL_VERSION = 8'h01;

  // ----------------------------------------------------------------------
  // link bring-up and buffering
  // ----------------------------------------------------------------------
  localparam int HS_COUNT    = 8;
  localparam int HS_CNT_BITS = $clog2(HS_COUNT + 1);

  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 16;

  typedef logic [PKT_BITS-1:0] pkt_t;

  typedef enum logic [1:0] {
    LINK_RESET,
    LINK_HSHK,
    LINK_UP
  } link_state_t;

  // frame checksum, xor of the eight packet bytes
  function automatic logic [7:0] pkt_csum(input pkt_t pkt);
    logic [7:0] sum;
    sum = 8'h00;
    for (int i = 0; i < PKT_BITS / 8; i++) begin
      sum = sum ^ pkt[8*i +: 8];
    end
    return sum;
  endfunction

endpackage
